//--- design/align_rx_detect.sv
`timescale 1ns/10ps

module align_rx_detect
	import sata_phy_pkg::*;
(
	input logic DCM_CLK2X_OUT,
	input logic PHYRESET,
	input rx_byte_t rx,
	input logic align_hunt,
	output logic align_seen,
	output logic nonalign_ok
);

	localparam int CNT_W = $clog2(NONALIGN_NEEDED + 1);
	localparam logic [CNT_W-1:0] CNT_DONE = CNT_W'(NONALIGN_NEEDED);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(NONALIGN_NEEDED - 1);

	align_idx_t match_idx;
	align_idx_t grp_idx;
	logic [CNT_W-1:0] grp_cnt;
	tx_byte_t exp_byte;
	logic byte_ok;
	logic hit;
	logic first_hit;
	logic full_match;
	logic grp_end;

	////////////////////////////////////////
	// byte matcher
	////////////////////////////////////////
	always_comb
	begin
		byte_ok = !rx.disp_err && !rx.not_in_table && rx.byte_aligned;
		exp_byte = align_byte(match_idx);
		hit = byte_ok && (rx.data == exp_byte.data);
		first_hit = byte_ok && (rx.data == K28_5);
		full_match = hit && (match_idx == ALIGN_IDX_LAST);
		grp_end = (grp_idx == ALIGN_IDX_LAST);
	end

	always_ff @(posedge DCM_CLK2X_OUT or posedge PHYRESET)
	begin
		if (PHYRESET)
			match_idx <= '0;
		else if (hit)
			match_idx <= full_match ? align_idx_t'(0) : match_idx + 1'b1;
		// a stray K28.5 may still open a new ALIGN
		else if (first_hit)
			match_idx <= align_idx_t'(1);
		else
			match_idx <= '0;
	end

	////////////////////////////////////////
	// non-ALIGN primitive count
	////////////////////////////////////////
	always_ff @(posedge DCM_CLK2X_OUT or posedge PHYRESET)
	begin
		if (PHYRESET)
		begin
			grp_idx <= '0;
			grp_cnt <= '0;
			align_seen <= 1'b0;
			nonalign_ok <= 1'b0;
		end
		else
		begin
			align_seen <= align_hunt && full_match;
			nonalign_ok <= !align_hunt && !full_match && grp_end && (grp_cnt == CNT_LAST);
			// groups restart at the end of every ALIGN
			if (align_hunt || full_match)
			begin
				grp_idx <= '0;
				grp_cnt <= '0;
			end
			else
			begin
				grp_idx <= grp_idx + 1'b1;
				if (grp_end && grp_cnt != CNT_DONE)
					grp_cnt <= grp_cnt + 1'b1;
			end
		end
	end

endmodule

//--- design/oob_burst_tx.sv
`timescale 1ns/10ps

module oob_burst_tx
	import sata_phy_pkg::*;
(
	input logic DCM_CLK2X_OUT,
	input logic PHYRESET,
	input logic burst_go,
	input com_type_e burst_type,
	input logic com_done,
	output oob_cmd_t oob_cmd,
	output logic burst_done
);

	typedef enum logic [1:0] {
		BT_IDLE,
		BT_START,
		BT_WAIT,
		BT_END
	} burst_state_e;

	burst_state_e bstate;

	// type first, then start, start held until the transceiver is done
	always_ff @(posedge DCM_CLK2X_OUT or posedge PHYRESET)
	begin
		if (PHYRESET)
		begin
			bstate <= BT_IDLE;
			oob_cmd <= '{com_start: 1'b0, com_type: COM_RESET};
			burst_done <= 1'b0;
		end
		else
		begin
			burst_done <= 1'b0;
			case (bstate)
				BT_IDLE:
					if (burst_go)
					begin
						oob_cmd.com_type <= burst_type;
						bstate <= BT_START;
					end
				BT_START:
				begin
					oob_cmd.com_start <= 1'b1;
					bstate <= BT_WAIT;
				end
				BT_WAIT:
					if (com_done)
					begin
						oob_cmd.com_start <= 1'b0;
						bstate <= BT_END;
					end
				default:
				begin
					burst_done <= 1'b1;
					bstate <= BT_IDLE;
				end
			endcase
		end
	end

endmodule

//--- design/oob_link_fsm.sv
`timescale 1ns/10ps

module oob_link_fsm
	import sata_phy_pkg::*;
(
	input logic DCM_CLK2X_OUT,
	input logic PHYRESET,
	input oob_status_t oob_status,
	input logic burst_done,
	input logic align_seen,
	input logic align_sent,
	input logic nonalign_ok,
	output logic burst_go,
	output com_type_e burst_type,
	output logic align_hunt,
	output tx_mode_e tx_mode,
	output logic phy_rdy
);

	localparam logic [TIMER_W-1:0] COM_LIMIT = TIMER_W'(COM_RETRY_CYCLES - 1);
	localparam logic [TIMER_W-1:0] ALIGN_LIMIT = TIMER_W'(ALIGN_WAIT_CYCLES - 1);
	localparam logic [TIMER_W-1:0] TIMER_MAX = '1;

	link_state_e state;
	link_state_e next_state;
	logic [TIMER_W-1:0] timer;

	////////////////////////////////////////
	// next state
	////////////////////////////////////////
	always_comb
	begin
		next_state = state;
		case (state)
			LS_IDLE:
				next_state = LS_COMRESET;
			LS_COMRESET:
				if (burst_done)
					next_state = LS_AWAIT_COMINIT;
			LS_AWAIT_COMINIT:
			begin
				if (oob_status.cominit_det)
					next_state = LS_AWAIT_NOCOMINIT;
				else if (timer == COM_LIMIT)
					next_state = LS_COMRESET;
			end
			LS_AWAIT_NOCOMINIT:
				if (!oob_status.cominit_det)
					next_state = LS_COMWAKE;
			LS_COMWAKE:
				if (burst_done)
					next_state = LS_AWAIT_COMWAKE;
			LS_AWAIT_COMWAKE:
			begin
				if (oob_status.comwake_det)
					next_state = LS_AWAIT_NOCOMWAKE;
				else if (timer == COM_LIMIT)
					next_state = LS_COMRESET;
			end
			LS_AWAIT_NOCOMWAKE:
				if (!oob_status.comwake_det)
					next_state = LS_AWAIT_ALIGN;
			LS_AWAIT_ALIGN:
			begin
				if (align_seen)
					next_state = LS_SEND_ALIGN;
				else if (timer == ALIGN_LIMIT)
					next_state = LS_COMRESET;
			end
			LS_SEND_ALIGN:
				if (align_sent)
					next_state = LS_AWAIT_NONALIGN;
			LS_AWAIT_NONALIGN:
			begin
				if (nonalign_ok)
					next_state = LS_READY;
				else if (timer == ALIGN_LIMIT)
					next_state = LS_COMRESET;
			end
			LS_READY:
				next_state = LS_READY;
			default:
				next_state = LS_IDLE;
		endcase
	end

	// state and shared retry timer, cleared on each state change
	always_ff @(posedge DCM_CLK2X_OUT or posedge PHYRESET)
	begin
		if (PHYRESET)
		begin
			state <= LS_IDLE;
			timer <= '0;
		end
		else
		begin
			state <= next_state;
			if (next_state != state)
				timer <= '0;
			else if (timer != TIMER_MAX)
				timer <= timer + 1'b1;
		end
	end

	////////////////////////////////////////
	// stage controls, aligned with state
	////////////////////////////////////////
	always_ff @(posedge DCM_CLK2X_OUT or posedge PHYRESET)
	begin
		if (PHYRESET)
		begin
			burst_go <= 1'b0;
			burst_type <= COM_RESET;
			align_hunt <= 1'b0;
			tx_mode <= TXM_D10_2;
			phy_rdy <= 1'b0;
		end
		else
		begin
			// one burst request on entry to either burst state
			burst_go <= (next_state != state) &&
				(next_state == LS_COMRESET || next_state == LS_COMWAKE);
			burst_type <= (next_state == LS_COMWAKE) ? COM_WAKE : COM_RESET;
			align_hunt <= (next_state == LS_AWAIT_ALIGN);
			phy_rdy <= (next_state == LS_READY);
			case (next_state)
				LS_SEND_ALIGN, LS_AWAIT_NONALIGN: tx_mode <= TXM_ALIGN;
				LS_READY: tx_mode <= TXM_USER;
				default: tx_mode <= TXM_D10_2;
			endcase
		end
	end

endmodule

//--- design/sata_phy_ctrl.sv
`timescale 1ns/10ps

module sata_phy_ctrl
	import sata_phy_pkg::*;
(
	input logic DCM_CLK2X_OUT,
	input logic PHYRESET,
	input rx_byte_t rx,
	input oob_status_t oob_status,
	input tx_byte_t user_tx,
	output tx_byte_t tx,
	output oob_cmd_t oob_cmd,
	output logic phy_rdy
);

	logic burst_go;
	com_type_e burst_type;
	logic burst_done;
	logic align_hunt;
	logic align_seen;
	logic nonalign_ok;
	logic align_sent;
	tx_mode_e tx_mode;

	////////////////////////////////////////
	// link state machine
	////////////////////////////////////////
	oob_link_fsm link_fsm0 (
		.DCM_CLK2X_OUT (DCM_CLK2X_OUT),
		.PHYRESET      (PHYRESET),
		.oob_status    (oob_status),
		.burst_done    (burst_done),
		.align_seen    (align_seen),
		.align_sent    (align_sent),
		.nonalign_ok   (nonalign_ok),
		.burst_go      (burst_go),
		.burst_type    (burst_type),
		.align_hunt    (align_hunt),
		.tx_mode       (tx_mode),
		.phy_rdy       (phy_rdy)
	);

	// out-of-band stage
	oob_burst_tx burst_tx0 (
		.DCM_CLK2X_OUT (DCM_CLK2X_OUT),
		.PHYRESET      (PHYRESET),
		.burst_go      (burst_go),
		.burst_type    (burst_type),
		.com_done      (oob_status.com_done),
		.oob_cmd       (oob_cmd),
		.burst_done    (burst_done)
	);

	// alignment and data stages
	align_rx_detect align_rx0 (
		.DCM_CLK2X_OUT (DCM_CLK2X_OUT),
		.PHYRESET      (PHYRESET),
		.rx            (rx),
		.align_hunt    (align_hunt),
		.align_seen    (align_seen),
		.nonalign_ok   (nonalign_ok)
	);

	tx_byte_gen tx_gen0 (
		.DCM_CLK2X_OUT (DCM_CLK2X_OUT),
		.PHYRESET      (PHYRESET),
		.tx_mode       (tx_mode),
		.user_tx       (user_tx),
		.tx            (tx),
		.align_sent    (align_sent)
	);

endmodule

//--- design/sata_phy_pkg.sv
package sata_phy_pkg;

	////////////////////////////////////////
	// byte and primitive constants
	////////////////////////////////////////
	localparam logic [7:0] K28_5 = 8'hBC;
	localparam logic [7:0] D10_2 = 8'h4A;
	localparam logic [7:0] D27_3 = 8'h7B;
	localparam int ALIGN_LEN = 4;

	// retry timer limits, in cycles
	localparam int COM_RETRY_CYCLES = 100;
	localparam int ALIGN_WAIT_CYCLES = 200;
	localparam int NONALIGN_NEEDED = 6;
	localparam int TIMER_W = 8;

	////////////////////////////////////////
	// types
	////////////////////////////////////////
	typedef enum logic {
		COM_RESET,
		COM_WAKE
	} com_type_e;

	typedef enum logic [3:0] {
		LS_IDLE,
		LS_COMRESET,
		LS_AWAIT_COMINIT,
		LS_AWAIT_NOCOMINIT,
		LS_COMWAKE,
		LS_AWAIT_COMWAKE,
		LS_AWAIT_NOCOMWAKE,
		LS_AWAIT_ALIGN,
		LS_SEND_ALIGN,
		LS_AWAIT_NONALIGN,
		LS_READY
	} link_state_e;

	typedef enum logic [1:0] {
		TXM_D10_2,
		TXM_ALIGN,
		TXM_USER
	} tx_mode_e;

	typedef struct packed {
		logic [7:0] data;
		logic charisk;
	} tx_byte_t;

	typedef struct packed {
		logic [7:0] data;
		logic disp_err;
		logic not_in_table;
		logic byte_aligned;
	} rx_byte_t;

	// transceiver rx status levels
	typedef struct packed {
		logic cominit_det;
		logic comwake_det;
		logic com_done;
	} oob_status_t;

	typedef struct packed {
		logic com_start;
		com_type_e com_type;
	} oob_cmd_t;

	// byte position inside one ALIGN primitive
	typedef logic [$clog2(ALIGN_LEN)-1:0] align_idx_t;
	localparam align_idx_t ALIGN_IDX_LAST = align_idx_t'(ALIGN_LEN - 1);

	// ALIGN is K28.5 D10.2 D10.2 D27.3, only the first byte is a K char
	function automatic tx_byte_t align_byte(input align_idx_t idx);
		tx_byte_t b;
		case (idx)
			align_idx_t'(0): b = '{data: K28_5, charisk: 1'b1};
			ALIGN_IDX_LAST: b = '{data: D27_3, charisk: 1'b0};
			default: b = '{data: D10_2, charisk: 1'b0};
		endcase
		return b;
	endfunction

endpackage

//--- design/tx_byte_gen.sv
`timescale 1ns/10ps

module tx_byte_gen
	import sata_phy_pkg::*;
(
	input logic DCM_CLK2X_OUT,
	input logic PHYRESET,
	input tx_mode_e tx_mode,
	input tx_byte_t user_tx,
	output tx_byte_t tx,
	output logic align_sent
);

	localparam tx_byte_t FILLER = '{data: D10_2, charisk: 1'b0};

	align_idx_t tx_idx;

	// position in the outgoing ALIGN
	always_ff @(posedge DCM_CLK2X_OUT or posedge PHYRESET)
	begin
		if (PHYRESET)
		begin
			tx_idx <= '0;
			align_sent <= 1'b0;
		end
		else
		begin
			align_sent <= (tx_mode == TXM_ALIGN) && (tx_idx == ALIGN_IDX_LAST);
			if (tx_mode == TXM_ALIGN)
				tx_idx <= tx_idx + 1'b1;
			else
				tx_idx <= '0;
		end
	end

	////////////////////////////////////////
	// transmit byte register
	////////////////////////////////////////
	always_ff @(posedge DCM_CLK2X_OUT or posedge PHYRESET)
	begin
		if (PHYRESET)
			tx <= FILLER;
		else
		begin
			case (tx_mode)
				TXM_ALIGN: tx <= align_byte(tx_idx);
				TXM_USER: tx <= user_tx;
				default: tx <= FILLER;
			endcase
		end
	end

endmodule

//--- sources.f
design/sata_phy_pkg.sv
design/oob_burst_tx.sv
design/align_rx_detect.sv
design/tx_byte_gen.sv
design/oob_link_fsm.sv
design/sata_phy_ctrl.sv
tb/sata_phy_chk.sv
tb/sata_phy_tb.sv

//--- tb/sata_phy_chk.sv
`timescale 1ns/10ps

module sata_phy_chk
	import sata_phy_pkg::*;
(
	input logic DCM_CLK2X_OUT,
	input logic PHYRESET,
	input oob_status_t oob_status,
	input oob_cmd_t oob_cmd,
	input logic phy_rdy
);

	int fail_cnt = 0;

	// burst request held until the transceiver reports done
	com_start_hold: assert property (@(posedge DCM_CLK2X_OUT) disable iff (PHYRESET)
		$fell(oob_cmd.com_start) |-> $past(oob_status.com_done))
	else
	begin
		fail_cnt++;
		$error("com_start fell without com_done");
	end

	com_type_stable: assert property (@(posedge DCM_CLK2X_OUT) disable iff (PHYRESET)
		oob_cmd.com_start |-> $stable(oob_cmd.com_type))
	else
	begin
		fail_cnt++;
		$error("com_type changed during a burst");
	end

	// ready is only left through reset
	phy_rdy_held: assert property (@(posedge DCM_CLK2X_OUT)
		$fell(phy_rdy) |-> PHYRESET)
	else
	begin
		fail_cnt++;
		$error("phy_rdy fell while out of reset");
	end

endmodule

bind sata_phy_ctrl sata_phy_chk chk0 (
	.DCM_CLK2X_OUT (DCM_CLK2X_OUT),
	.PHYRESET      (PHYRESET),
	.oob_status    (oob_status),
	.oob_cmd       (oob_cmd),
	.phy_rdy       (phy_rdy)
);

//--- tb/sata_phy_tb.sv
`timescale 1ns/10ps

module sata_phy_tb
	import sata_phy_pkg::*;
();

	localparam int RESET_CYCLES = 16;
	// well above the summed length of the four tests
	localparam int MAX_CYCLES = 4000;
	localparam int DATA_CYCLES = 200;
	localparam int DONE_DELAY = 3;
	localparam int REPLY_LEAD = 2;
	localparam int REPLY_LEN = 4;
	localparam logic [31:0] LFSR_SEED = 32'hf84b_14af;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

	typedef enum {RXP_FILL, RXP_ALIGN, RXP_NONALIGN, RXP_BAD} rx_phase_e;

	logic DCM_CLK2X_OUT;
	logic PHYRESET;
	rx_byte_t rx;
	oob_status_t oob_status;
	tx_byte_t user_tx;
	tx_byte_t tx;
	oob_cmd_t oob_cmd;
	logic phy_rdy;

	int err_cnt = 0;
	int check_cnt = 0;
	int cycle_cnt = 0;
	int data_checks = 0;
	int align_checks = 0;
	logic [31:0] lfsr;

	// device model state
	rx_phase_e rx_phase;
	bit dev_silent;
	bit dev_corrupt;
	bit host_align;
	bit prev_start;
	bit bad_sel;
	int com_cnt;
	int reply_cnt;
	int rx_idx;
	int nonalign_rx;
	com_type_e reply_type;
	tx_byte_t dev_byte;
	oob_cmd_t bursts[$];
	int burst_cycles[$];

	// compare process state
	bit rdy_seen;
	int align_pos;
	tx_byte_t prev_user;

	sata_phy_ctrl dut0 (
		.DCM_CLK2X_OUT (DCM_CLK2X_OUT),
		.PHYRESET      (PHYRESET),
		.rx            (rx),
		.oob_status    (oob_status),
		.user_tx       (user_tx),
		.tx            (tx),
		.oob_cmd       (oob_cmd),
		.phy_rdy       (phy_rdy)
	);

	initial
	begin
		DCM_CLK2X_OUT = 1'b0;
		forever #4 DCM_CLK2X_OUT = ~DCM_CLK2X_OUT;
	end

	////////////////////////////////////////
	// reference model and LFSR
	////////////////////////////////////////
	// ALIGN is K28.5 D10.2 D10.2 D27.3
	// user bytes pass with one cycle of delay
	function automatic tx_byte_t ref_tx(input tx_mode_e mode, input int idx,
		input tx_byte_t user);
		tx_byte_t b;
		b = '{data: D10_2, charisk: 1'b0};
		if (mode == TXM_USER)
			b = user;
		else if (mode == TXM_ALIGN && idx == 0)
			b = '{data: K28_5, charisk: 1'b1};
		else if (mode == TXM_ALIGN && idx == ALIGN_LEN - 1)
			b = '{data: D27_3, charisk: 1'b0};
		return b;
	endfunction

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
	endfunction

	task automatic draw_user_byte(output tx_byte_t b);
		logic [8:0] bits;
		int i;
		for (i = 0; i < 9; i++)
		begin
			bits[i] = lfsr[0];
			lfsr = lfsr_step(lfsr);
		end
		b = bits;
	endtask

	////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////
	task automatic check_tx(input string name, input tx_byte_t exp, input tx_byte_t act);
		check_cnt++;
		if (act !== exp)
		begin
			err_cnt++;
			$display("** Error [%s] expected data %h charisk %b, actual data %h charisk %b",
				name, exp.data, exp.charisk, act.data, act.charisk);
		end
	endtask

	task automatic check_cmd(input string name, input oob_cmd_t exp, input oob_cmd_t act);
		check_cnt++;
		if (act !== exp)
		begin
			err_cnt++;
			$display("** Error [%s] expected start %b type %b, actual start %b type %b",
				name, exp.com_start, exp.com_type, act.com_start, act.com_type);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		check_cnt++;
		if (act !== exp)
		begin
			err_cnt++;
			$display("** Error [%s] expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic finish_run(input bit timed_out);
		int total;
		total = err_cnt + dut0.chk0.fail_cnt;
		$display("checks: %0d  errors: %0d  assertion failures: %0d",
			check_cnt, err_cnt, dut0.chk0.fail_cnt);
		if (timed_out || total != 0)
			$display("Simulation finished: FAIL");
		else
			$display("Simulation finished: PASS");
		$finish;
	endtask

	always @(posedge DCM_CLK2X_OUT)
	begin
		cycle_cnt++;
		if (cycle_cnt >= MAX_CYCLES)
		begin
			$display("timeout: the cycle limit was reached before the tests finished");
			finish_run(1'b1);
		end
	end

	////////////////////////////////////////
	// device model
	////////////////////////////////////////
	always @(posedge DCM_CLK2X_OUT)
	begin
		#1;
		if (PHYRESET)
		begin
			oob_status = '0;
			rx = '{data: D10_2, disp_err: 1'b0, not_in_table: 1'b0, byte_aligned: 1'b1};
			rx_phase = RXP_FILL;
			reply_type = COM_RESET;
			host_align = 1'b0;
			prev_start = 1'b0;
			bad_sel = 1'b0;
			com_cnt = 0;
			reply_cnt = 0;
			rx_idx = 0;
			bursts.delete();
			burst_cycles.delete();
		end
		else
		begin
			// log each burst request as it starts
			if (oob_cmd.com_start && !prev_start)
			begin
				bursts.push_back(oob_cmd);
				burst_cycles.push_back(cycle_cnt);
			end
			prev_start = oob_cmd.com_start;
			if (reply_cnt > 0)
				reply_cnt--;
			if (oob_cmd.com_start && !oob_status.com_done)
			begin
				if (com_cnt == DONE_DELAY)
				begin
					oob_status.com_done = 1'b1;
					reply_type = oob_cmd.com_type;
				end
				else
					com_cnt++;
			end
			else if (!oob_cmd.com_start && oob_status.com_done)
			begin
				oob_status.com_done = 1'b0;
				com_cnt = 0;
				if (!dev_silent)
					reply_cnt = REPLY_LEAD + REPLY_LEN;
				if (reply_type == COM_RESET)
				begin
					rx_phase = RXP_FILL;
					host_align = 1'b0;
				end
				else if (!dev_silent)
					rx_phase = dev_corrupt ? RXP_BAD : RXP_ALIGN;
			end
			oob_status.cominit_det = (reply_type == COM_RESET) &&
				(reply_cnt inside {[1:REPLY_LEN]});
			oob_status.comwake_det = (reply_type == COM_WAKE) &&
				(reply_cnt inside {[1:REPLY_LEN]});
			// switch to non-ALIGN at a primitive boundary once the host answers
			if (rx_phase == RXP_ALIGN && tx.charisk && tx.data == K28_5)
				host_align = 1'b1;
			if (rx_phase == RXP_ALIGN && host_align && rx_idx == 0)
				rx_phase = RXP_NONALIGN;
			dev_byte = ref_tx(TXM_ALIGN, rx_idx, '0);
			case (rx_phase)
				RXP_ALIGN:
					rx = '{data: dev_byte.data, disp_err: 1'b0, not_in_table: 1'b0,
						byte_aligned: 1'b1};
				// either a disparity error or lost byte alignment
				RXP_BAD:
					rx = '{data: dev_byte.data, disp_err: bad_sel, not_in_table: 1'b0,
						byte_aligned: bad_sel};
				default:
					rx = '{data: D10_2, disp_err: 1'b0, not_in_table: 1'b0, byte_aligned: 1'b1};
			endcase
			if (rx_idx == ALIGN_LEN - 1)
				bad_sel = !bad_sel;
			rx_idx = (rx_idx + 1) % ALIGN_LEN;
		end
	end

	// non-ALIGN bytes taken in by the DUT
	always @(posedge DCM_CLK2X_OUT)
	begin
		if (PHYRESET)
			nonalign_rx = 0;
		else if (rx_phase == RXP_NONALIGN)
			nonalign_rx++;
	end

	// tx checked mid-cycle against the reference
	always @(negedge DCM_CLK2X_OUT)
	begin
		if (PHYRESET)
		begin
			rdy_seen = 1'b0;
			align_pos = 0;
		end
		else
		begin
			if (rdy_seen)
			begin
				check_tx("data pass-through", ref_tx(TXM_USER, 0, prev_user), tx);
				data_checks++;
			end
			else if (align_pos != 0 || tx.charisk)
			begin
				check_tx("host ALIGN", ref_tx(TXM_ALIGN, align_pos, prev_user), tx);
				align_pos = (align_pos + 1) % ALIGN_LEN;
				align_checks++;
			end
			rdy_seen = phy_rdy;
			prev_user = user_tx;
		end
	end

	////////////////////////////////////////
	// tests
	////////////////////////////////////////
	task automatic next_cycle();
		@(posedge DCM_CLK2X_OUT);
		#1;
	endtask

	task automatic reset_values(input string name);
		check_bit(name, 1'b0, phy_rdy);
		check_bit(name, 1'b0, oob_cmd.com_start);
		check_tx(name, ref_tx(TXM_D10_2, 0, '0), tx);
	endtask

	task automatic apply_reset(input string name);
		next_cycle();
		PHYRESET = 1'b1;
		user_tx = '0;
		repeat (RESET_CYCLES)
		begin
			next_cycle();
			reset_values({name, " in reset"});
		end
		PHYRESET = 1'b0;
		next_cycle();
		reset_values({name, " after reset"});
	endtask

	task automatic wait_bursts(input int n, input string name, input bit filler_only);
		while (bursts.size() < n)
		begin
			next_cycle();
			check_bit({name, " phy_rdy"}, 1'b0, phy_rdy);
			if (filler_only)
				check_tx({name, " filler"}, ref_tx(TXM_D10_2, 0, '0), tx);
		end
	endtask

	task automatic test_bring_up();
		dev_silent = 1'b0;
		dev_corrupt = 1'b0;
		apply_reset("bring-up");
		while (!phy_rdy)
			next_cycle();
		if (nonalign_rx < NONALIGN_NEEDED * ALIGN_LEN)
		begin
			err_cnt++;
			$display("bring-up: phy_rdy rose after only %0d non-ALIGN bytes", nonalign_rx);
		end
		if (bursts.size() != 2)
		begin
			err_cnt++;
			$display("bring-up: expected two bursts before ready but saw %0d", bursts.size());
		end
		else
		begin
			check_cmd("bring-up first burst", '{com_start: 1'b1, com_type: COM_RESET}, bursts[0]);
			check_cmd("bring-up second burst", '{com_start: 1'b1, com_type: COM_WAKE}, bursts[1]);
		end
		if (align_checks < ALIGN_LEN)
		begin
			err_cnt++;
			$display("bring-up: the host sent no full ALIGN before ready");
		end
	endtask

	task automatic test_data();
		tx_byte_t b;
		repeat (DATA_CYCLES)
		begin
			next_cycle();
			draw_user_byte(b);
			user_tx = b;
			check_bit("data phy_rdy", 1'b1, phy_rdy);
		end
		next_cycle();
		if (data_checks < DATA_CYCLES)
		begin
			err_cnt++;
			$display("data: only %0d bytes were compared", data_checks);
		end
	endtask

	task automatic test_cominit_retry();
		int i;
		dev_silent = 1'b1;
		apply_reset("cominit retry");
		wait_bursts(3, "cominit retry", 1'b0);
		for (i = 0; i < 3; i++)
		begin
			check_cmd("cominit retry burst", '{com_start: 1'b1, com_type: COM_RESET}, bursts[i]);
			if (i > 0)
				check_bit("cominit retry gap", 1'b1,
					burst_cycles[i] - burst_cycles[i - 1] >= COM_RETRY_CYCLES);
		end
	endtask

	task automatic test_bad_align();
		dev_silent = 1'b0;
		dev_corrupt = 1'b1;
		apply_reset("bad ALIGN");
		wait_bursts(3, "bad ALIGN", 1'b1);
		check_cmd("bad ALIGN first burst", '{com_start: 1'b1, com_type: COM_RESET}, bursts[0]);
		check_cmd("bad ALIGN second burst", '{com_start: 1'b1, com_type: COM_WAKE}, bursts[1]);
		check_cmd("bad ALIGN retry burst", '{com_start: 1'b1, com_type: COM_RESET}, bursts[2]);
		check_bit("bad ALIGN retry gap", 1'b1,
			burst_cycles[2] - burst_cycles[1] >= ALIGN_WAIT_CYCLES);
	endtask

	initial
	begin
		PHYRESET = 1'b1;
		rx = '{data: D10_2, disp_err: 1'b0, not_in_table: 1'b0, byte_aligned: 1'b1};
		oob_status = '0;
		user_tx = '0;
		dev_silent = 1'b0;
		dev_corrupt = 1'b0;
		lfsr = LFSR_SEED;
		test_bring_up();
		test_data();
		test_cominit_retry();
		test_bad_align();
		finish_run(1'b0);
	end

endmodule
